/* hdl/flow_led_pkg.sv */
`default_nettype none

package flow_led_pkg;

  localparam int BYTE_W = 8;

  // serial link
  localparam int UART_CLKS_PER_BIT = 434;  // 115200 baud at 50 MHz
  localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);
  localparam int UART_FRAME_W = 10;  // start + 8 data + stop

  // pin banks reached over the link
  localparam int PIN_BANKS = 8;
  localparam int PIN_ADDR_W = 3;

  // seven segment chain behind two 595s
  localparam int SEG_DIGITS = 8;
  localparam int SEG_DIG_W = $clog2(SEG_DIGITS);
  localparam int SEG_BYTES = 4;
  localparam int SEG_WORD_W = 16;  // pattern byte + select byte
  localparam int SEG_BIT_W = $clog2(SEG_WORD_W + 1);
  localparam int SEG_CLK_DIV = 2;  // sys clocks per half period
  localparam int SEG_DIV_W = $clog2(SEG_CLK_DIV + 1);

  typedef logic [BYTE_W-1:0] byte_t;

  typedef logic [PIN_BANKS-1:0][BYTE_W-1:0] pin_bank_t;

  typedef logic [SEG_BYTES-1:0][BYTE_W-1:0] seg_bytes_t;

  // first byte of every command
  typedef struct packed {
    logic                         wr;    // 1 = write, next byte is data
    logic [BYTE_W-PIN_ADDR_W-2:0] rsvd;
    logic [PIN_ADDR_W-1:0]        addr;  // bank number
  } cmd_t;

endpackage

`default_nettype wire

/* hdl/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx import flow_led_pkg::*; (
  input  logic  sys_clk,
  input  logic  rst,
  input  logic  rxd,
  output byte_t rx_data,
  output logic  rx_valid
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t             state;
  logic                  rxd_meta;
  logic                  rxd_sync;
  logic [UART_CNT_W-1:0] clk_cnt;
  logic [2:0]            bit_cnt;
  byte_t                 shift;
  logic                  bit_end;
  logic                  half_end;

  assign bit_end  = (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1));
  assign half_end = (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1));

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;  // line idles high
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (!rxd_sync) begin
            state <= RX_START;  // falling edge seen
          end
        end
        RX_START: begin
          if (half_end) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rxd_sync ? RX_IDLE : RX_DATA;  // high again means a glitch
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'(BYTE_W - 1)) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          // mid stop bit, framing error drops the byte
          if (bit_end) begin
            rx_valid <= rxd_sync;
            state    <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == RX_DATA && bit_end) begin
      shift <= {rxd_sync, shift[BYTE_W-1:1]};  // lsb arrives first
    end
    if (state == RX_STOP && bit_end && rxd_sync) begin
      rx_data <= shift;
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx import flow_led_pkg::*; (
  input  logic  sys_clk,
  input  logic  rst,
  input  logic  tx_start,
  input  byte_t tx_data,
  output logic  txd,
  output logic  tx_busy
);

  logic [UART_FRAME_W-1:0] frame;
  logic [UART_CNT_W-1:0]   clk_cnt;
  logic [3:0]              bit_cnt;
  logic                    bit_end;

  assign bit_end = (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1));

  // frame fills with ones as it drains, so the line rests high
  assign txd = frame[0];

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      frame   <= '1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx_busy <= 1'b0;
    end else if (!tx_busy) begin
      clk_cnt <= '0;
      bit_cnt <= '0;
      if (tx_start) begin
        frame   <= {1'b1, tx_data, 1'b0};  // stop, data, start
        tx_busy <= 1'b1;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
      frame   <= {1'b1, frame[UART_FRAME_W-1:1]};
      if (bit_cnt == 4'(UART_FRAME_W - 1)) begin
        tx_busy <= 1'b0;  // stop bit done
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/cmd_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_bridge import flow_led_pkg::*; (
  input  logic      sys_clk,
  input  logic      rst,
  input  byte_t     rx_data,
  input  logic      rx_valid,
  input  logic      tx_busy,
  output logic      tx_start,
  output byte_t     tx_data,
  input  pin_bank_t in_pins,
  output pin_bank_t out_pins,
  output logic      busy
);

  typedef enum logic {
    BR_CMD,
    BR_WDATA
  } br_state_t;

  br_state_t             state;
  cmd_t                  cmd;
  logic [PIN_ADDR_W-1:0] wr_addr;
  logic                  pend_valid;
  byte_t                 pend_data;
  byte_t                 rd_byte;
  logic                  rd_req;
  logic                  tx_free;
  logic                  launch_pend;
  logic                  launch_now;

  assign cmd     = cmd_t'(rx_data);
  assign rd_req  = rx_valid && (state == BR_CMD) && !cmd.wr;
  assign rd_byte = in_pins[cmd.addr];  // sampled in the rx_valid cycle

  // a start already issued counts as busy until the tx sees it
  assign tx_free     = !tx_busy && !tx_start;
  assign launch_pend = pend_valid && tx_free;
  assign launch_now  = rd_req && tx_free && !pend_valid;

  assign busy = (state == BR_WDATA) || pend_valid || tx_start || tx_busy;

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      state    <= BR_CMD;
      out_pins <= '0;
    end else begin
      case (state)
        BR_CMD: begin
          if (rx_valid && cmd.wr) begin
            state <= BR_WDATA;
          end
        end
        default: begin
          if (rx_valid) begin
            out_pins[wr_addr] <= rx_data;
            state             <= BR_CMD;
          end
        end
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_valid && state == BR_CMD) begin
      wr_addr <= cmd.addr;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      tx_start   <= 1'b0;
      pend_valid <= 1'b0;
    end else begin
      tx_start <= launch_pend || launch_now;
      if (rd_req && !launch_now) begin
        pend_valid <= 1'b1;  // newest read wins the slot
      end else if (launch_pend) begin
        pend_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (launch_pend) begin
      tx_data <= pend_data;
    end else if (launch_now) begin
      tx_data <= rd_byte;
    end
    if (rd_req && !launch_now) begin
      pend_data <= rd_byte;
    end
  end

endmodule

`default_nettype wire

/* hdl/seg_led_hex595.sv */
`timescale 1ns/100ps
`default_nettype none

module seg_led_hex595 import flow_led_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst,
  input  seg_bytes_t seg_data,
  output logic       clk,
  output logic       dat,
  output logic       str
);

  logic [SEG_DIV_W-1:0]        div_cnt;
  logic                        tick;
  logic [SEG_BIT_W-1:0]        bit_cnt;
  logic [SEG_DIG_W-1:0]        digit;
  logic [SEG_DIG_W-1:0]        next_digit;
  logic [SEG_WORD_W-1:0]       shift;
  logic [SEG_BYTES*BYTE_W-1:0] seg_flat;
  logic [3:0]                  nibble;
  byte_t                       seg_pat;
  byte_t                       dig_sel;
  logic                        word_done;
  logic                        first_load;
  logic                        load;

  assign seg_flat   = seg_data;
  assign next_digit = (digit == SEG_DIG_W'(SEG_DIGITS - 1)) ? '0 : digit + 1'b1;
  assign nibble     = seg_flat[{next_digit, 2'b00} +: 4];  // digit 0 is the low nibble
  assign dig_sel    = BYTE_W'(1) << next_digit;

  // bit order {dp,g,f,e,d,c,b,a}, low lights the segment
  always_comb begin
    case (nibble)
      4'h0: seg_pat = 8'hc0;
      4'h1: seg_pat = 8'hf9;
      4'h2: seg_pat = 8'ha4;
      4'h3: seg_pat = 8'hb0;
      4'h4: seg_pat = 8'h99;
      4'h5: seg_pat = 8'h92;
      4'h6: seg_pat = 8'h82;
      4'h7: seg_pat = 8'hf8;
      4'h8: seg_pat = 8'h80;
      4'h9: seg_pat = 8'h90;
      4'ha: seg_pat = 8'h88;
      4'hb: seg_pat = 8'h83;
      4'hc: seg_pat = 8'hc6;
      4'hd: seg_pat = 8'ha1;
      4'he: seg_pat = 8'h86;
      default: seg_pat = 8'h8e;
    endcase
  end

  assign tick       = (div_cnt == SEG_DIV_W'(SEG_CLK_DIV - 1));
  assign word_done  = (bit_cnt == SEG_BIT_W'(SEG_WORD_W - 1));
  assign first_load = (bit_cnt == SEG_BIT_W'(SEG_WORD_W));  // only right after reset
  assign load       = tick && (clk ? word_done : first_load);
  assign dat        = shift[SEG_WORD_W-1];  // msb first

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      div_cnt <= '0;
      clk     <= 1'b0;
      str     <= 1'b0;
      bit_cnt <= SEG_BIT_W'(SEG_WORD_W);
      digit   <= SEG_DIG_W'(SEG_DIGITS - 1);  // wraps to digit 0 on first load
      shift   <= '0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      str     <= tick && clk && word_done;  // latch the finished word, clk now low
      if (tick && !first_load) begin
        clk <= !clk;
      end
      if (load) begin
        bit_cnt <= '0;
        digit   <= next_digit;
        shift   <= {seg_pat, dig_sel};
      end else if (tick && clk) begin
        bit_cnt <= bit_cnt + 1'b1;
        shift   <= {shift[SEG_WORD_W-2:0], 1'b0};  // next bit on the falling edge
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/flow_led.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_led import flow_led_pkg::*; (
  input  logic      sys_clk,  // 50 MHz board clock
  input  logic      rst,
  input  logic      uart_rx_from_pc,
  input  pin_bank_t in_pins,
  output logic      uart_tx_to_pc,
  output logic      segled_clk,
  output logic      segled_dat,
  output logic      segled_str,
  output logic      led,
  output pin_bank_t out_pins
);

  byte_t      rx_data;
  logic       rx_valid;
  byte_t      tx_data;
  logic       tx_start;
  logic       tx_busy;
  seg_bytes_t seg_data;

  // two input banks low, two output banks high
  assign seg_data = {out_pins[3], out_pins[2], in_pins[1], in_pins[0]};

  uart_rx uart_rx_i (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .rxd      (uart_rx_from_pc),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  uart_tx uart_tx_i (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .txd      (uart_tx_to_pc),
    .tx_busy  (tx_busy)
  );

  cmd_bridge cmd_bridge_i (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .in_pins  (in_pins),
    .out_pins (out_pins),
    .busy     (led)  // board led follows bridge busy
  );

  seg_led_hex595 seg_led_hex595_i (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .seg_data (seg_data),
    .clk      (segled_clk),
    .dat      (segled_dat),
    .str      (segled_str)
  );

endmodule

`default_nettype wire

/* tb/clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
  output logic sys_clk,
  output logic rst
);

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;  // 100 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge sys_clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* tb/flow_led_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_led_assert (
  input logic sys_clk,
  input logic rst,
  input logic segled_clk,
  input logic segled_str,
  input logic tx_start,
  input logic tx_busy,
  input logic uart_tx_to_pc
);

  int fail_count = 0;  // failed properties so far

  // 595 latch pulse sits in the low half of the shift clock
  str_clk_low: assert property (@(posedge sys_clk) disable iff (rst)
    segled_str |-> !segled_clk)
    else begin
      $error("segled_str high while segled_clk is high");
      fail_count++;
    end

  str_one_cycle: assert property (@(posedge sys_clk) disable iff (rst)
    segled_str |=> !segled_str)
    else begin
      $error("segled_str lasted longer than one cycle");
      fail_count++;
    end

  tx_start_idle: assert property (@(posedge sys_clk) disable iff (rst)
    tx_start |-> !tx_busy)
    else begin
      $error("tx_start raised while tx_busy was high");
      fail_count++;
    end

  line_idle_high: assert property (@(posedge sys_clk) disable iff (rst)
    !tx_busy |-> uart_tx_to_pc)
    else begin
      $error("uart_tx_to_pc low while the transmitter is idle");
      fail_count++;
    end

endmodule

`default_nettype wire

/* tb/flow_led_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_led_tb import flow_led_pkg::*; ();

  logic                  sys_clk;
  logic                  rst;
  logic                  uart_rx_from_pc;
  pin_bank_t             in_pins;
  logic                  uart_tx_to_pc;
  logic                  segled_clk;
  logic                  segled_dat;
  logic                  segled_str;
  logic                  led;
  pin_bank_t             out_pins;
  pin_bank_t             model_out;  // expected out banks
  logic [31:0]           lcg_state;
  byte_t                 rx_q[$];    // bytes seen on uart_tx_to_pc
  int                    errors;
  int                    checks;
  int                    test_base;
  logic                  mon_active;
  int                    mon_cnt;
  int                    mon_bit;
  byte_t                 mon_byte;
  logic                  seg_clk_q;
  logic [SEG_WORD_W-1:0] sr_595;
  logic [SEG_DIG_W-1:0]  sel_k;
  int                    str_count;
  byte_t                 seen;
  logic                  disp_check;

  // {dp,g,f,e,d,c,b,a}, segments active low, dp dark
  byte_t font [16] = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
                       8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};

  clk_gen clk_gen_i (.sys_clk(sys_clk), .rst(rst));

  flow_led flow_led_i (
    .sys_clk         (sys_clk),
    .rst             (rst),
    .uart_rx_from_pc (uart_rx_from_pc),
    .in_pins         (in_pins),
    .uart_tx_to_pc   (uart_tx_to_pc),
    .segled_clk      (segled_clk),
    .segled_dat      (segled_dat),
    .segled_str      (segled_str),
    .led             (led),
    .out_pins        (out_pins)
  );

  bind flow_led flow_led_assert flow_led_assert_i (
    .sys_clk       (sys_clk),
    .rst           (rst),
    .segled_clk    (segled_clk),
    .segled_str    (segled_str),
    .tx_start      (tx_start),
    .tx_busy       (tx_busy),
    .uart_tx_to_pc (uart_tx_to_pc)
  );

  function automatic byte_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];  // upper bits are the most random
  endfunction

  function automatic byte_t cmd_byte(input logic wr, input logic [PIN_ADDR_W-1:0] addr);
    cmd_t c;
    c.wr   = wr;
    c.rsvd = '0;
    c.addr = addr;
    return c;
  endfunction

  // expected 595 word for digit k
  function automatic logic [SEG_WORD_W-1:0] digit_word(input logic [SEG_DIG_W-1:0] k,
                                                       input pin_bank_t ins,
                                                       input pin_bank_t outs);
    logic [31:0] shown;
    logic [3:0]  nib;
    byte_t       sel;
    shown = {outs[3], outs[2], ins[1], ins[0]};
    nib   = shown[{k, 2'b00} +: 4];
    sel   = 8'd1 << k;
    return {font[nib], sel};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  task automatic send_byte(input byte_t data);
    logic [UART_FRAME_W-1:0] frame;
    frame = {1'b1, data, 1'b0};
    repeat (UART_FRAME_W) begin
      @(posedge sys_clk);
      uart_rx_from_pc <= frame[0];
      frame = frame >> 1;
      repeat (UART_CLKS_PER_BIT - 1) @(posedge sys_clk);
    end
  endtask

  task automatic write_bank(input logic [PIN_ADDR_W-1:0] addr, input byte_t data);
    send_byte(cmd_byte(1'b1, addr));
    send_byte(data);
    model_out[addr] = data;
    check_value("out_pins", 64'(out_pins), 64'(model_out));
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    @(posedge sys_clk);  // rst is settled from the first edge on
    while (rst && waited < 20) begin
      @(posedge sys_clk);
      waited++;
    end
    if (rst) abort_run("reset was never released");
  endtask

  task automatic wait_reply(input int n);
    int waited;
    waited = 0;
    while (rx_q.size() < n && waited < 12 * UART_FRAME_W * UART_CLKS_PER_BIT) begin
      @(posedge sys_clk);
      waited++;
    end
    if (rx_q.size() < n) abort_run("no reply byte arrived on uart_tx_to_pc in time");
  endtask

  task automatic wait_strobes(input int n);
    int target;
    int waited;
    target = str_count + n;
    waited = 0;
    while (str_count < target && waited < n * 400) begin
      @(posedge sys_clk);
      waited++;
    end
    if (str_count < target) abort_run("segled_str stopped pulsing");
  endtask

  // UART receive model, samples each bit mid-period
  always @(posedge sys_clk) begin
    if (rst) begin
      mon_active <= 1'b0;
    end else if (!mon_active) begin
      if (!uart_tx_to_pc) begin
        mon_active <= 1'b1;
        mon_cnt    <= UART_CLKS_PER_BIT / 2 - 1;
        mon_bit    <= 0;
      end
    end else if (mon_cnt != 0) begin
      mon_cnt <= mon_cnt - 1;
    end else begin
      mon_cnt <= UART_CLKS_PER_BIT - 1;
      mon_bit <= mon_bit + 1;
      if (mon_bit == 0) begin
        check_value("uart_tx_to_pc start bit", 64'(uart_tx_to_pc), 64'(0));
      end else if (mon_bit <= 8) begin
        mon_byte <= {uart_tx_to_pc, mon_byte[7:1]};  // lsb first
      end else begin
        check_value("uart_tx_to_pc stop bit", 64'(uart_tx_to_pc), 64'(1));
        rx_q.push_back(mon_byte);
        mon_active <= 1'b0;
      end
    end
  end

  // 595 chain model and display compare
  always @(posedge sys_clk) begin
    if (rst) begin
      seg_clk_q <= 1'b0;
      str_count <= 0;
      seen      <= '0;
    end else begin
      seg_clk_q <= segled_clk;
      if (segled_clk && !seg_clk_q) begin
        sr_595 <= {sr_595[SEG_WORD_W-2:0], segled_dat};
      end
      if (!disp_check) begin
        seen <= '0;
      end
      if (segled_str) begin
        str_count <= str_count + 1;
        if (disp_check) begin
          sel_k = SEG_DIG_W'($clog2(sr_595[7:0]));
          check_value("595 select bits set", 64'($countones(sr_595[7:0])), 64'(1));
          check_value("595 word", 64'(sr_595), 64'(digit_word(sel_k, in_pins, model_out)));
          seen <= seen | sr_595[7:0];
        end
      end
    end
  end

  initial begin
    logic [PIN_ADDR_W-1:0] a;
    byte_t                 d;
    errors          = 0;
    checks          = 0;
    test_base       = 0;
    lcg_state       = 32'd35;
    model_out       = '0;
    uart_rx_from_pc <= 1'b1;  // idle line
    in_pins         <= '0;
    disp_check      <= 1'b0;
    wait_reset();

    check_value("out_pins", 64'(out_pins), 64'(0));
    check_value("led", 64'(led), 64'(0));
    check_value("uart_tx_to_pc", 64'(uart_tx_to_pc), 64'(1));
    end_test("reset state");

    for (int b = 0; b < PIN_BANKS; b++) begin
      write_bank(PIN_ADDR_W'(b), rand_byte());
    end
    end_test("writes");

    @(posedge sys_clk);
    for (int b = 0; b < PIN_BANKS; b++) begin
      in_pins[PIN_ADDR_W'(b)] <= rand_byte();
    end
    for (int b = 0; b < PIN_BANKS; b++) begin
      a = PIN_ADDR_W'(b);
      send_byte(cmd_byte(1'b0, a));
      wait_reply(1);
      check_value("uart_tx_to_pc byte", 64'(rx_q.pop_front()), 64'(in_pins[a]));
    end
    end_test("reads");

    send_byte(cmd_byte(1'b0, 3'd5));  // second read lands while first reply is on the line
    send_byte(cmd_byte(1'b0, 3'd2));
    wait_reply(2);
    check_value("uart_tx_to_pc first byte", 64'(rx_q.pop_front()), 64'(in_pins[5]));
    check_value("uart_tx_to_pc second byte", 64'(rx_q.pop_front()), 64'(in_pins[2]));
    end_test("back-to-back reads");

    @(posedge sys_clk);
    in_pins[0] <= rand_byte();
    in_pins[1] <= rand_byte();
    write_bank(3'd2, rand_byte());
    write_bank(3'd3, rand_byte());
    wait_strobes(SEG_DIGITS);  // one full cycle to settle
    disp_check <= 1'b1;
    @(posedge sys_clk);
    wait_strobes(2 * SEG_DIGITS);
    check_value("digit selects seen", 64'(seen), 64'(8'hff));
    disp_check <= 1'b0;
    end_test("display");

    d = rand_byte();
    send_byte(cmd_byte(1'b1, 3'd6));
    check_value("led", 64'(led), 64'(1));  // waiting for the data byte
    send_byte(d);
    model_out[6] = d;
    check_value("led", 64'(led), 64'(0));
    check_value("out_pins", 64'(out_pins), 64'(model_out));
    end_test("busy");

    errors = errors + flow_led_i.flow_led_assert_i.fail_count;  // bound property failures
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/flow_led_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_bridge.sv
hdl/seg_led_hex595.sv
hdl/flow_led.sv
tb/clk_gen.sv
tb/flow_led_assert.sv
tb/flow_led_tb.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := flow_led_tb
FILE_LIST := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR) -o sim
	-./$(OBJ_DIR)/sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || grep -q "%Error" $(LOG) || \
	  ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not pass"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
